//--- aemb.f
common/aembIsaPkg.sv
common/aembCtrlPkg.sv
source/aembFetch.sv
decode/aembDecode.sv
source/aembRegFile.sv
execute/aembExecute.sv
source/aembTop.sv
dv/aembMemModel.sv
dv/aembTb.sv

//--- common/aembCtrlPkg.sv
/* Pipeline control definitions
   Operand, ALU, load/store and branch selects, data-bus cycle states */
package aembCtrlPkg;

	// Operand A source
	typedef enum logic [1:0] {
		SRC_RA,
		SRC_PC,
		SRC_FWD	// Execute result register
	} srcSelE;

	// Operand B source, store data for stores
	typedef enum logic [1:0] {
		TGT_RB,
		TGT_IMM,
		TGT_FWD
	} tgtSelE;

	typedef enum logic [1:0] {
		ALU_ADD,	// Add, reverse subtract, addresses
		ALU_LOGIC,
		ALU_SHIFT,
		ALU_PASSB	// Absolute branch target
	} aluSelE;

	typedef enum logic [1:0] {LDST_NONE, LDST_LOAD, LDST_STORE} ldstSelE;

	typedef enum logic [1:0] {BRA_NONE, BRA_UNCOND, BRA_COND} braSelE;

	// Data-bus cycle, WAIT once the first strobe cycle went unanswered
	typedef enum logic {BUS_IDLE, BUS_WAIT} busStateE;

	// Logic functions, same as the low opcode bits
	localparam logic [1:0] LOGIC_OR = 2'd0;
	localparam logic [1:0] LOGIC_AND = 2'd1;
	localparam logic [1:0] LOGIC_XOR = 2'd2;

endpackage

//--- common/aembIsaPkg.sv
/* Instruction-set definitions
   Word and field types, major opcodes, branch condition codes */
package aembIsaPkg;

	typedef logic [31:0] wordT;	// Data word and byte address
	typedef logic [31:0] instrT;	// Instruction after byte swap
	typedef logic [5:0] opcodeT;
	typedef logic [4:0] regIdxT;
	typedef logic [15:0] immT;

	localparam int REG_COUNT = 32;
	localparam int WORD_BYTES = 4;	// PC step

	// Bit 3 of the opcode selects the immediate form
	localparam int OPC_IMMFORM_BIT = 3;

	// Arithmetic group
	localparam opcodeT OPC_ADD = 6'o00;
	localparam opcodeT OPC_RSUB = 6'o01;	// rd = rb - ra

	// Logic group, low two bits pick the function
	localparam opcodeT OPC_OR = 6'o40;
	localparam opcodeT OPC_AND = 6'o41;
	localparam opcodeT OPC_XOR = 6'o42;

	// One-bit right shift, register form only
	localparam opcodeT OPC_SHIFT = 6'o44;
	localparam int SHIFT_LOGICAL_BIT = 6;	// Set in imm field for srl

	// Prefix, upper half of the next immediate
	localparam opcodeT OPC_IMM = 6'o54;

	// Branches
	localparam opcodeT OPC_BR = 6'o46;	// Flags in the ra field
	localparam opcodeT OPC_BCC = 6'o47;	// Condition in the rd field
	localparam int BR_ABS_BIT = 3;
	localparam int BR_LINK_BIT = 2;

	// Word memory access
	localparam opcodeT OPC_LW = 6'o62;
	localparam opcodeT OPC_SW = 6'o66;

	// Bubble, an OR into r0
	localparam opcodeT OPC_NOP = 6'o40;

	// Condition codes, register A against zero
	localparam logic [2:0] CC_EQ = 3'o0;
	localparam logic [2:0] CC_NE = 3'o1;
	localparam logic [2:0] CC_LT = 3'o2;
	localparam logic [2:0] CC_LE = 3'o3;
	localparam logic [2:0] CC_GT = 3'o4;
	localparam logic [2:0] CC_GE = 3'o5;

endpackage

//--- decode/aembDecode.sv
/* Decode stage
   Instruction latch, opcode decode, IMM prefix and forwarding selects */
module aembDecode
	import aembIsaPkg::*, aembCtrlPkg::*;
(
	input logic nclk,
	input logic nrst,
	input logic stall_i,
	input logic flush_i,	// Taken branch in execute
	input instrT instr_i,	// Big-endian from the bus
	input wordT pc_i,
	output regIdxT rdIdx_o,
	output regIdxT raIdx_o,
	output regIdxT rbIdx_o,	// Holds rd for stores
	output wordT simm_o,
	output wordT linkPc_o,	// Address of this instruction
	output srcSelE srcSel_o,
	output tgtSelE tgtSel_o,
	output aluSelE aluSel_o,
	output ldstSelE ldstSel_o,
	output braSelE braSel_o,
	output logic [2:0] cond_o,
	output logic [1:0] logicOp_o,
	output logic arith_o,	// Rsub or arithmetic shift
	output logic absolute_o,
	output logic regWe_o
);

	instrT instr;
	opcodeT opc;
	opcodeT opcBase;	// Immediate-form bit cleared
	regIdxT rd, ra, rb;
	immT imm;
	logic fAdd, fRsub, fLogic, fShift, fImm, fBr, fBcc, fLw, fSw;
	logic hazA, hazB, hazD;
	logic immFlag;	// Previous instruction was IMM
	immT immHi;
	srcSelE srcNext;
	tgtSelE tgtNext;
	aluSelE aluNext;
	ldstSelE ldstNext;
	braSelE braNext;
	logic weNext;

	// Endian swap
	assign instr = {instr_i[7:0], instr_i[15:8], instr_i[23:16], instr_i[31:24]};

	// Flush turns the word into a bubble
	assign opc = flush_i ? OPC_NOP : instr[31:26];
	assign rd = flush_i ? regIdxT'(0) : instr[25:21];
	assign ra = instr[20:16];
	assign rb = instr[15:11];
	assign imm = instr[15:0];

	assign opcBase = opc & ~opcodeT'(1 << OPC_IMMFORM_BIT);

	// Opcode groups
	assign fImm = (opc == OPC_IMM);
	assign fShift = (opc == OPC_SHIFT);	// Exact, shares base with IMM
	assign fAdd = (opcBase == OPC_ADD);
	assign fRsub = (opcBase == OPC_RSUB);
	assign fLogic = (opcBase == OPC_OR) || (opcBase == OPC_AND) || (opcBase == OPC_XOR);
	assign fBr = (opcBase == OPC_BR);
	assign fBcc = (opcBase == OPC_BCC);
	assign fLw = (opcBase == OPC_LW);
	assign fSw = (opcBase == OPC_SW);

	// Hazards against the instruction now in execute
	assign hazA = regWe_o && (rdIdx_o == ra);
	assign hazB = regWe_o && (rdIdx_o == rb);
	assign hazD = regWe_o && (rdIdx_o == rd);	// Store data

	always_comb begin
		if (fBr) begin
			srcNext = SRC_PC;	// Relative target from the adder
		end else if (hazA) begin
			srcNext = SRC_FWD;
		end else begin
			srcNext = SRC_RA;
		end

		// Stores take the offset from simm, B carries the data
		if (fSw) begin
			tgtNext = hazD ? TGT_FWD : TGT_RB;
		end else if (opc[OPC_IMMFORM_BIT]) begin
			tgtNext = TGT_IMM;
		end else if (hazB) begin
			tgtNext = TGT_FWD;
		end else begin
			tgtNext = TGT_RB;
		end

		if (fShift) begin
			aluNext = ALU_SHIFT;
		end else if (fLogic) begin
			aluNext = ALU_LOGIC;
		end else if (fBr && ra[BR_ABS_BIT]) begin
			aluNext = ALU_PASSB;
		end else begin
			aluNext = ALU_ADD;
		end

		ldstNext = fLw ? LDST_LOAD : (fSw ? LDST_STORE : LDST_NONE);
		braNext = fBr ? BRA_UNCOND : (fBcc ? BRA_COND : BRA_NONE);

		// r0 is never a destination
		weNext = (fAdd || fRsub || fLogic || fShift || fLw || (fBr && ra[BR_LINK_BIT]))
			&& (rd != '0);
	end

	// Control registers
	always_ff @(posedge nclk) begin
		if (!nrst) begin
			srcSel_o <= SRC_RA;
			tgtSel_o <= TGT_RB;
			aluSel_o <= ALU_ADD;
			ldstSel_o <= LDST_NONE;
			braSel_o <= BRA_NONE;
			regWe_o <= 1'b0;
			immFlag <= 1'b0;
		end else if (!stall_i) begin
			srcSel_o <= srcNext;
			tgtSel_o <= tgtNext;
			aluSel_o <= aluNext;
			ldstSel_o <= ldstNext;
			braSel_o <= braNext;
			regWe_o <= weNext;
			immFlag <= fImm;	// Lasts one instruction
		end
	end

	// Fields and immediate
	always_ff @(posedge nclk) begin
		if (!stall_i) begin
			rdIdx_o <= rd;
			raIdx_o <= ra;
			rbIdx_o <= fSw ? rd : rb;
			simm_o <= immFlag ? {immHi, imm} : {{16{imm[15]}}, imm};
			linkPc_o <= pc_i;
			cond_o <= rd[2:0];
			logicOp_o <= opc[1:0];
			arith_o <= fRsub || (fShift && !imm[SHIFT_LOGICAL_BIT]);
			absolute_o <= fBr && ra[BR_ABS_BIT];
			if (fImm) begin
				immHi <= imm;
			end
		end
	end

	// Forwarding from r0 would feed a value the register file never holds
	assert property (@(posedge nclk) disable iff (!nrst) regWe_o |-> (rdIdx_o != '0));

endmodule

//--- dv/aembMemModel.sv
/* Test memories
   Instruction ROM with the test program, data RAM with random acknowledge delay */
module aembMemModel
	import aembIsaPkg::*;
(
	input logic nclk,
	input logic nrst,
	input wordT iwbAdr_i,
	output instrT iwbDat_o,	// Big-endian byte lanes
	input wordT dwbAdr_i,
	input wordT dwbDat_i,	// Store data from the core
	input logic dwbStb_i,
	input logic dwbWe_i,
	output wordT dwbDat_o,
	output logic dwbAck_o
);

	instrT rom [64];
	wordT ram [64];
	instrT romWord;
	int romFill;	// Next free ROM word
	int waitLeft;	// -1 while no request is open
	integer seed = 32'h18ff76f2;
	int storeRegs [11] = '{10, 2, 3, 4, 5, 11, 12, 6, 7, 8, 9};
	int takenReg [6] = '{0, 1, 6, 0, 1, 0};	// r0 zero, r1 positive, r6 negative
	int fallReg [6] = '{1, 0, 0, 1, 0, 6};
	logic [2:0] ccList [6] = '{CC_EQ, CC_NE, CC_LT, CC_LE, CC_GT, CC_GE};

	function automatic instrT immForm(opcodeT opc, regIdxT rd, regIdxT ra, immT imm);
		return {opc, rd, ra, imm};
	endfunction

	function automatic instrT regForm(opcodeT opc, regIdxT rd, regIdxT ra, regIdxT rb);
		return {opc, rd, ra, rb, 11'h000};
	endfunction

	function automatic opcodeT immOpc(opcodeT opc);
		return opc | opcodeT'(1 << OPC_IMMFORM_BIT);
	endfunction

	task automatic put(instrT word);
		rom[romFill] = word;
		romFill++;
	endtask

	// Memory order puts the opcode byte on the low lane
	assign romWord = rom[iwbAdr_i[7:2]];
	assign iwbDat_o = {romWord[7:0], romWord[15:8], romWord[23:16], romWord[31:24]};

	initial begin
		dwbDat_o = '0;
		dwbAck_o = 1'b0;
		waitLeft = -1;
		romFill = 0;
		for (int i = 0; i < 64; i++) begin
			rom[i] = immForm(immOpc(OPC_OR), 5'd0, 5'd0, immT'(i * 4));	// Writes r0 only
			ram[i] = {~immT'(i * 4), immT'(i * 4)};
		end
		put(immForm(immOpc(OPC_ADD), 5'd1, 5'd0, 16'd5));
		put(immForm(immOpc(OPC_ADD), 5'd2, 5'd1, 16'd7));	// Forward A
		put(regForm(OPC_RSUB, 5'd3, 5'd1, 5'd2));	// Forward B
		put(regForm(OPC_XOR, 5'd4, 5'd3, 5'd2));
		put(regForm(OPC_AND, 5'd5, 5'd4, 5'd2));
		put(immForm(immOpc(OPC_OR), 5'd11, 5'd5, 16'h0031));
		put(regForm(OPC_ADD, 5'd12, 5'd11, 5'd3));
		put(immForm(immOpc(OPC_ADD), 5'd6, 5'd0, 16'hFFF0));	// Sign extended
		put(immForm(OPC_SHIFT, 5'd7, 5'd6, 16'h0000));	// sra
		put(immForm(OPC_SHIFT, 5'd8, 5'd6, 16'h0040));	// srl
		put(immForm(OPC_IMM, 5'd0, 5'd0, 16'h1234));
		put(immForm(immOpc(OPC_ADD), 5'd9, 5'd0, 16'h5678));
		put(immForm(immOpc(OPC_RSUB), 5'd10, 5'd1, 16'd100));
		for (int i = 0; i < 11; i++) begin
			put(immForm(immOpc(OPC_SW), regIdxT'(storeRegs[i]), 5'd0, immT'(8'h80 + 4 * i)));
		end
		// Load then dependent add and store
		put(immForm(immOpc(OPC_LW), 5'd13, 5'd0, 16'h0084));
		put(regForm(OPC_ADD, 5'd14, 5'd13, 5'd1));
		put(immForm(immOpc(OPC_SW), 5'd14, 5'd0, 16'h00AC));
		// Taken over a bad store, then not taken onto a marker
		for (int k = 0; k < 6; k++) begin
			put(immForm(immOpc(OPC_BCC), {2'b00, ccList[k]}, regIdxT'(takenReg[k]), 16'd8));
			put(immForm(immOpc(OPC_SW), 5'd1, 5'd0, 16'h00FC));
			put(immForm(immOpc(OPC_BCC), {2'b00, ccList[k]}, regIdxT'(fallReg[k]), 16'd8));
			put(immForm(immOpc(OPC_SW), 5'd1, 5'd0, immT'(8'hC0 + 4 * k)));
		end
		put(immForm(immOpc(OPC_BR), 5'd16, 5'd4, 16'd8));	// Relative with link
		put(immForm(immOpc(OPC_SW), 5'd1, 5'd0, 16'h00FC));
		put(immForm(immOpc(OPC_SW), 5'd16, 5'd0, 16'h00D8));
		put(immForm(immOpc(OPC_BR), 5'd0, 5'd8, immT'((romFill + 3) * 4)));	// Absolute
		put(immForm(immOpc(OPC_SW), 5'd1, 5'd0, 16'h00FC));
		put(immForm(immOpc(OPC_SW), 5'd1, 5'd0, 16'h00FC));
		put(immForm(immOpc(OPC_ADD), 5'd0, 5'd1, 16'd9));	// Dropped write
		put(immForm(immOpc(OPC_SW), 5'd0, 5'd0, 16'h00DC));
		put(immForm(immOpc(OPC_BR), 5'd0, 5'd0, 16'd0));	// Park here
	end

	// Data RAM, one ack per request after 0 to 3 extra cycles
	always @(negedge nclk) begin
		dwbAck_o <= 1'b0;
		if (!nrst || !dwbStb_i) begin
			waitLeft = -1;
		end else begin
			if (waitLeft < 0) begin
				waitLeft = $unsigned($random(seed)) % 4;	// New request
			end
			if (waitLeft == 0) begin
				dwbAck_o <= 1'b1;
				dwbDat_o <= ram[dwbAdr_i[7:2]];
				if (dwbWe_i) begin
					ram[dwbAdr_i[7:2]] = dwbDat_i;
				end
				waitLeft = -1;
			end else begin
				waitLeft = waitLeft - 1;
			end
		end
	end

endmodule

//--- dv/aembTb.sv
/* Core testbench
   Clock, reset, expected store table, store-checking assertions, timeout */
module aembTb
	import aembIsaPkg::*;
();

	localparam int NUM_STORES = 20;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int DRAIN_CYCLES = 20;

	logic nclk;
	logic nrst;
	wordT iwbAdr, dwbAdr, dwbDatW, dwbDatR;
	instrT iwbDat;
	logic dwbStb, dwbWe, dwbAck, storeAck;
	wordT expAdr [NUM_STORES];
	wordT expDat [NUM_STORES];
	int tableLen;
	int storeIdx;	// Next table entry to compare
	int valueErrs;
	int otherErrs;

	aembTop aembTop_inst (
		.nclk(nclk), .nrst(nrst), .iwbAdr_o(iwbAdr), .iwbDat_i(iwbDat),
		.dwbAdr_o(dwbAdr), .dwbDat_o(dwbDatW), .dwbStb_o(dwbStb), .dwbWe_o(dwbWe),
		.dwbDat_i(dwbDatR), .dwbAck_i(dwbAck)
	);

	aembMemModel aembMemModel_inst (
		.nclk(nclk), .nrst(nrst), .iwbAdr_i(iwbAdr), .iwbDat_o(iwbDat),
		.dwbAdr_i(dwbAdr), .dwbDat_i(dwbDatW), .dwbStb_i(dwbStb), .dwbWe_i(dwbWe),
		.dwbDat_o(dwbDatR), .dwbAck_o(dwbAck)
	);

	initial nclk = 1'b0;
	always #10 nclk = ~nclk;

	task automatic expectStore(input wordT adr, input wordT dat);
		expAdr[tableLen] = adr;
		expDat[tableLen] = dat;
		tableLen++;
	endtask

	assign storeAck = dwbStb && dwbWe && dwbAck;

	always_ff @(posedge nclk) begin
		if (!nrst) begin
			storeIdx <= 0;
		end else if (storeAck) begin
			storeIdx <= storeIdx + 1;
		end
	end

	// Boot vector
	assert property (@(posedge nclk) $rose(nrst) |-> (iwbAdr == '0))
		else begin
			valueErrs++;
			$display("ERR %0t iwbAdr_o expected %h actual %h", $time, 32'h0, $sampled(iwbAdr));
		end

	// First data-bus request is the first store
	assert property (@(posedge nclk) disable iff (!nrst) (storeIdx == 0 && dwbStb) |-> dwbWe)
		else begin
			otherErrs++;
			$display("Strobe raised at %0t before the first store", $time);
		end

	assert property (@(posedge nclk) disable iff (!nrst)
		(dwbStb && !dwbAck) |=> (dwbStb && $stable(dwbAdr) && $stable(dwbWe) && $stable(dwbDatW)))
		else begin
			otherErrs++;
			$display("Data-bus request changed before acknowledge at %0t", $time);
		end

	assert property (@(posedge nclk) disable iff (!nrst) storeAck |-> (storeIdx < NUM_STORES))
		else begin
			otherErrs++;
			$display("Unexpected extra store to %h at %0t", $sampled(dwbAdr), $time);
		end

	// Skipped stores show up here as an address mismatch
	assert property (@(posedge nclk) disable iff (!nrst)
		(storeAck && storeIdx < NUM_STORES) |-> (dwbAdr == expAdr[storeIdx]))
		else begin
			valueErrs++;
			$display("ERR %0t dwbAdr_o expected %h actual %h", $time,
				expAdr[$sampled(storeIdx)], $sampled(dwbAdr));
		end

	assert property (@(posedge nclk) disable iff (!nrst)
		(storeAck && storeIdx < NUM_STORES) |-> (dwbDatW == expDat[storeIdx]))
		else begin
			valueErrs++;
			$display("ERR %0t dwbDat_o expected %h actual %h", $time,
				expDat[$sampled(storeIdx)], $sampled(dwbDatW));
		end

	initial begin
		int cycles;
		nrst = 1'b0;
		tableLen = 0;
		valueErrs = 0;
		otherErrs = 0;
		cycles = 0;
		// Rsub is rb - ra with r1 holding 5 and r2 holding 5 + 7
		expectStore(32'h80, 32'd100 - 32'd5);
		expectStore(32'h84, 32'd5 + 32'd7);
		expectStore(32'h88, 32'd12 - 32'd5);
		expectStore(32'h8C, 32'd7 ^ 32'd12);
		expectStore(32'h90, (32'd7 ^ 32'd12) & 32'd12);
		expectStore(32'h94, 32'd8 | 32'h31);
		expectStore(32'h98, (32'd8 | 32'h31) + 32'd7);
		expectStore(32'h9C, {{16{1'b1}}, 16'hFFF0});	// -16 sign extended
		expectStore(32'hA0, $signed({{16{1'b1}}, 16'hFFF0}) >>> 1);
		expectStore(32'hA4, {{16{1'b1}}, 16'hFFF0} >> 1);
		expectStore(32'hA8, {16'h1234, 16'h5678});	// IMM prefix
		expectStore(32'hAC, (32'd5 + 32'd7) + 32'd5);	// Load plus r1
		for (int k = 0; k < 6; k++) begin
			expectStore(32'hC0 + 4 * k, 32'd5);	// Fall-through markers
		end
		expectStore(32'hD8, 32'd51 * 4);	// Link is the branch address
		expectStore(32'hDC, 32'd0);
		repeat (3) @(posedge nclk);
		@(negedge nclk);
		nrst = 1'b1;
		while (storeIdx < NUM_STORES && cycles < TIMEOUT_CYCLES) begin
			@(negedge nclk);
			cycles++;
		end
		if (storeIdx < NUM_STORES) begin
			otherErrs++;
			$display("Timeout after %0d cycles, only %0d of %0d stores seen",
				cycles, storeIdx, NUM_STORES);
		end else begin
			repeat (DRAIN_CYCLES) @(negedge nclk);	// Core parked, no store may follow
		end
		$display("Errors: value %0d, other %0d", valueErrs, otherErrs);
		if (valueErrs + otherErrs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- execute/aembExecute.sv
/* Execute and writeback stage
   Operand muxes, ALU, branch resolution, data-bus cycle, result register */
module aembExecute
	import aembIsaPkg::*, aembCtrlPkg::*;
(
	input logic nclk,
	input logic nrst,
	input regIdxT rdIdx_i,
	input regIdxT raIdx_i,
	input regIdxT rbIdx_i,
	input wordT simm_i,
	input wordT linkPc_i,
	input srcSelE srcSel_i,
	input tgtSelE tgtSel_i,
	input aluSelE aluSel_i,
	input ldstSelE ldstSel_i,
	input braSelE braSel_i,
	input logic [2:0] cond_i,
	input logic [1:0] logicOp_i,
	input logic arith_i,
	input logic absolute_i,
	input logic regWe_i,
	input wordT regA_i,
	input wordT regB_i,
	input wordT dwbDat_i,
	input logic dwbAck_i,
	output logic branchTaken_o,
	output wordT branchTarget_o,
	output logic stall_o,
	output logic regWe_o,
	output regIdxT regWaddr_o,
	output wordT result_o,	// Writeback and forwarding source
	output wordT dwbAdr_o,
	output wordT dwbDat_o,
	output logic dwbStb_o,
	output logic dwbWe_o
);

	wordT opA, regBFwd, opB, aluB, sum, logicOut, aluOut, resultNext;
	logic memOp, condMet, isZero, isNeg;
	busStateE busState;

	always_comb begin
		case (srcSel_i)
			SRC_PC: opA = linkPc_i;
			SRC_FWD: opA = result_o;
			default: opA = regA_i;
		endcase
	end

	assign regBFwd = (tgtSel_i == TGT_FWD) ? result_o : regB_i;
	assign opB = (tgtSel_i == TGT_IMM) ? simm_i : regBFwd;
	assign aluB = (ldstSel_i == LDST_STORE) ? simm_i : opB;	// Store offset

	// Reverse subtract as ~a + b + 1
	assign sum = (arith_i ? ~opA : opA) + aluB + wordT'(arith_i);

	always_comb begin
		case (logicOp_i)
			LOGIC_AND: logicOut = opA & opB;
			LOGIC_XOR: logicOut = opA ^ opB;
			default: logicOut = opA | opB;	// LOGIC_OR
		endcase
		case (aluSel_i)
			ALU_LOGIC: aluOut = logicOut;
			ALU_SHIFT: aluOut = {arith_i & opA[31], opA[31:1]};
			ALU_PASSB: aluOut = opB;
			default: aluOut = sum;
		endcase
	end

	// Comparator on forwarded A
	assign isZero = (opA == '0);
	assign isNeg = opA[31];
	always_comb begin
		case (cond_i)
			CC_EQ: condMet = isZero;
			CC_NE: condMet = !isZero;
			CC_LT: condMet = isNeg;
			CC_LE: condMet = isNeg || isZero;
			CC_GT: condMet = !isNeg && !isZero;
			CC_GE: condMet = !isNeg;
			default: condMet = 1'b0;
		endcase
	end

	assign branchTaken_o = (braSel_i == BRA_UNCOND) || ((braSel_i == BRA_COND) && condMet);
	assign branchTarget_o = (braSel_i == BRA_COND) ? linkPc_i + opB :
		(absolute_i ? opB : aluOut);

	// Data bus, request held by the stall until acknowledge
	assign memOp = (ldstSel_i != LDST_NONE);
	assign dwbStb_o = memOp;
	assign dwbWe_o = (ldstSel_i == LDST_STORE);
	assign dwbAdr_o = sum;
	assign dwbDat_o = regBFwd;
	assign stall_o = memOp && !dwbAck_i;

	always_ff @(posedge nclk) begin
		if (!nrst) begin
			busState <= BUS_IDLE;
		end else begin
			case (busState)
				BUS_IDLE: if (stall_o) busState <= BUS_WAIT;	// No ack in first cycle
				BUS_WAIT: if (dwbAck_i) busState <= BUS_IDLE;
				default: busState <= BUS_IDLE;
			endcase
		end
	end

	always_comb begin
		if (ldstSel_i == LDST_LOAD) begin
			resultNext = dwbDat_i;	// Sampled in the ack cycle
		end else if (braSel_i == BRA_UNCOND) begin
			resultNext = linkPc_i;
		end else begin
			resultNext = aluOut;
		end
	end

	// Result register, drives the register-file write port
	always_ff @(posedge nclk) begin
		if (!nrst) begin
			regWe_o <= 1'b0;
		end else if (!stall_o) begin
			regWe_o <= regWe_i;
		end
	end
	always_ff @(posedge nclk) begin
		if (!stall_o) begin
			result_o <= resultNext;
			regWaddr_o <= rdIdx_i;
		end
	end

	// Request stays put through every wait cycle
	assert property (@(posedge nclk) disable iff (!nrst)
		(busState == BUS_WAIT) |-> dwbStb_o && $stable(dwbAdr_o) && $stable(dwbWe_o));

	// Branches never share execute with a pending memory op
	assert property (@(posedge nclk) disable iff (!nrst) !(branchTaken_o && stall_o));

	// Decode chose forwarding against the instruction now in the result register
	assert property (@(posedge nclk) disable iff (!nrst)
		(srcSel_i == SRC_FWD) |-> regWe_o && (regWaddr_o == raIdx_i));
	assert property (@(posedge nclk) disable iff (!nrst)
		(tgtSel_i == TGT_FWD) |-> regWe_o && (regWaddr_o == rbIdx_i));

endmodule

//--- source/aembFetch.sv
/* Fetch stage
   Program counter, instruction-bus address and branch redirect */
module aembFetch
	import aembIsaPkg::*;
(
	input logic nclk,
	input logic nrst,
	input logic stall_i,	// Memory op pending in execute
	input logic branchTaken_i,
	input wordT branchTarget_i,
	output wordT pc_o	// Also the instruction-bus address
);

	wordT pcSeq;	// Next sequential address
	wordT pcNext;

	assign pcSeq = pc_o + wordT'(WORD_BYTES);

	// Redirect wins, the fetched word behind the branch is squashed in decode
	always_comb begin
		if (branchTaken_i) begin
			pcNext = {branchTarget_i[31:2], 2'b00};	// Word aligned
		end else begin
			pcNext = pcSeq;
		end
	end

	// Program counter
	always_ff @(posedge nclk) begin
		if (!nrst) begin
			pc_o <= '0;	// Boot vector
		end else if (!stall_i) begin
			pc_o <= pcNext;
		end
	end

endmodule

//--- source/aembRegFile.sv
/* Register file
   Two asynchronous read ports, one synchronous write port, r0 reads zero */
module aembRegFile
	import aembIsaPkg::*;
(
	input logic nclk,
	input logic nrst,
	input logic we_i,
	input regIdxT waddr_i,
	input regIdxT raddrA_i,
	input regIdxT raddrB_i,
	input wordT wdata_i,
	output wordT rdataA_o,
	output wordT rdataB_o
);

	wordT regs [REG_COUNT];

	// No writes while in reset, r0 stays untouched
	always_ff @(posedge nclk) begin
		if (nrst && we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdataA_o = (raddrA_i == '0) ? '0 : regs[raddrA_i];
	assign rdataB_o = (raddrB_i == '0) ? '0 : regs[raddrB_i];

endmodule

//--- source/aembTop.sv
/* Core top level
   Fetch, decode, execute and register file on the instruction and data buses */
module aembTop
	import aembIsaPkg::*, aembCtrlPkg::*;
(
	input logic nclk,
	input logic nrst,
	output wordT iwbAdr_o,	// Instruction bus
	input instrT iwbDat_i,
	output wordT dwbAdr_o,	// Data bus
	output wordT dwbDat_o,
	output logic dwbStb_o,
	output logic dwbWe_o,
	input wordT dwbDat_i,
	input logic dwbAck_i
);

	logic stall, branchTaken, regWe, rfWe;
	wordT branchTarget, simm, linkPc, regA, regB, result;
	regIdxT rdIdx, raIdx, rbIdx, rfWaddr;
	srcSelE srcSel;
	tgtSelE tgtSel;
	aluSelE aluSel;
	ldstSelE ldstSel;
	braSelE braSel;
	logic [2:0] cond;
	logic [1:0] logicOp;
	logic arith, absolute;

	aembFetch aembFetch_inst (
		.nclk(nclk), .nrst(nrst), .stall_i(stall), .branchTaken_i(branchTaken),
		.branchTarget_i(branchTarget), .pc_o(iwbAdr_o)
	);

	aembDecode aembDecode_inst (
		.nclk(nclk), .nrst(nrst), .stall_i(stall), .flush_i(branchTaken),
		.instr_i(iwbDat_i), .pc_i(iwbAdr_o),
		.rdIdx_o(rdIdx), .raIdx_o(raIdx), .rbIdx_o(rbIdx), .simm_o(simm), .linkPc_o(linkPc),
		.srcSel_o(srcSel), .tgtSel_o(tgtSel), .aluSel_o(aluSel), .ldstSel_o(ldstSel),
		.braSel_o(braSel), .cond_o(cond), .logicOp_o(logicOp), .arith_o(arith),
		.absolute_o(absolute), .regWe_o(regWe)
	);

	// Read indices come from the latched decode fields
	aembRegFile aembRegFile_inst (
		.nclk(nclk), .nrst(nrst), .we_i(rfWe), .waddr_i(rfWaddr),
		.raddrA_i(raIdx), .raddrB_i(rbIdx), .wdata_i(result),
		.rdataA_o(regA), .rdataB_o(regB)
	);

	aembExecute aembExecute_inst (
		.nclk(nclk), .nrst(nrst),
		.rdIdx_i(rdIdx), .raIdx_i(raIdx), .rbIdx_i(rbIdx), .simm_i(simm), .linkPc_i(linkPc),
		.srcSel_i(srcSel), .tgtSel_i(tgtSel), .aluSel_i(aluSel), .ldstSel_i(ldstSel),
		.braSel_i(braSel), .cond_i(cond), .logicOp_i(logicOp), .arith_i(arith),
		.absolute_i(absolute), .regWe_i(regWe), .regA_i(regA), .regB_i(regB),
		.dwbDat_i(dwbDat_i), .dwbAck_i(dwbAck_i),
		.branchTaken_o(branchTaken), .branchTarget_o(branchTarget), .stall_o(stall),
		.regWe_o(rfWe), .regWaddr_o(rfWaddr), .result_o(result),
		.dwbAdr_o(dwbAdr_o), .dwbDat_o(dwbDat_o), .dwbStb_o(dwbStb_o), .dwbWe_o(dwbWe_o)
	);

endmodule
